/* design/branch_predictor.sv */
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module branch_predictor import rv_core_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic [`XLEN-1:0] rd_pc_i,
    input  bp_update_t       update_i,
    output logic             taken_o,
    output logic [`XLEN-1:0] target_o,
    output logic             hit_o
);

    localparam int unsigned ENTRIES = 1 << `BP_INDEX_W;
    localparam int unsigned TAG_W   = `XLEN - `BP_INDEX_W - 2;

    logic [ENTRIES-1:0]     btb_valid;
    logic [TAG_W-1:0]       btb_tag    [ENTRIES];
    logic [`XLEN-1:0]       btb_target [ENTRIES];
    logic [1:0]             pht        [ENTRIES];
    logic [`BP_INDEX_W-1:0] rd_idx;
    logic [`BP_INDEX_W-1:0] wr_idx;
    logic [TAG_W-1:0]       rd_tag;
    logic [TAG_W-1:0]       wr_tag;

    // Word-aligned PCs, so index starts at bit 2
    assign rd_idx = rd_pc_i[`BP_INDEX_W+1:2];
    assign rd_tag = rd_pc_i[`XLEN-1:`BP_INDEX_W+2];
    assign wr_idx = update_i.pc[`BP_INDEX_W+1:2];
    assign wr_tag = update_i.pc[`XLEN-1:`BP_INDEX_W+2];

    // Lookup in fetch
    assign hit_o    = btb_valid[rd_idx] && (btb_tag[rd_idx] == rd_tag);
    assign target_o = btb_target[rd_idx];
    assign taken_o  = hit_o && pht[rd_idx][1];

    // Counters start weakly not-taken
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            btb_valid <= '0;
            for (int i = 0; i < ENTRIES; i++) begin
                pht[i] <= 2'b01;
            end
        end else if (update_i.valid) begin
            if (update_i.taken) begin
                btb_valid[wr_idx] <= 1'b1;
                if (pht[wr_idx] != 2'b11) begin
                    pht[wr_idx] <= pht[wr_idx] + 2'd1;
                end
            end else if (pht[wr_idx] != 2'b00) begin
                pht[wr_idx] <= pht[wr_idx] - 2'd1;
            end
        end
    end

    // Tag and target only written on a taken outcome
    always_ff @(posedge clk_i) begin
        if (update_i.valid && update_i.taken) begin
            btb_tag[wr_idx]    <= wr_tag;
            btb_target[wr_idx] <= update_i.target;
        end
    end

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module decode_stage import rv_core_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  if_id_t                 if_id_i,
    input  logic                   wb_wren_i,
    input  logic [`REG_ADDR_W-1:0] wb_addr_i,
    input  logic [`XLEN-1:0]       wb_data_i,
    output id_ex_t                 id_ex_o
);

    localparam int unsigned NREGS = 1 << `REG_ADDR_W;

    logic [`XLEN-1:0]       regs [1:NREGS-1];
    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       instr;
    alu_op_e                f3_op;
    logic                   writes_rd;

    assign instr  = if_id_i.instr;
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    // x0 is hardwired, a write landing this cycle is seen by the read
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wb_wren_i && wb_addr_i == addr) begin
            return wb_data_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_wren_i && wb_addr_i != '0) begin
            regs[wb_addr_i] <= wb_data_i;
        end
    end

    // Shared by OP and OP-IMM
    always_comb begin
        case (funct3)
            3'b001:  f3_op = ALU_SLL;
            3'b010:  f3_op = ALU_SLT;
            3'b100:  f3_op = ALU_XOR;
            3'b101:  f3_op = ALU_SRL;
            3'b110:  f3_op = ALU_OR;
            3'b111:  f3_op = ALU_AND;
            default: f3_op = ALU_ADD;
        endcase
    end

    always_comb begin
        id_ex_o           = '0;
        writes_rd         = 1'b0;
        id_ex_o.alu_op    = ALU_ADD;
        id_ex_o.opb_sel   = OPB_REG;
        case (opcode)
            `OPC_OP: begin
                id_ex_o.valid  = (funct3 != 3'b011) &&
                                 (funct7 == 7'h00 || (funct7 == 7'h20 && funct3 == 3'b000));
                id_ex_o.alu_op = funct7[5] ? ALU_SUB : f3_op;
                writes_rd      = 1'b1;
            end
            `OPC_OP_IMM: begin
                // No immediate shifts and no sltiu
                id_ex_o.valid   = funct3 inside {3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
                id_ex_o.alu_op  = f3_op;
                id_ex_o.opb_sel = OPB_IMM;
                id_ex_o.imm     = {{20{instr[31]}}, instr[31:20]};
                writes_rd       = 1'b1;
            end
            `OPC_LUI: begin
                id_ex_o.valid   = 1'b1;
                id_ex_o.alu_op  = ALU_PASS_B;
                id_ex_o.opb_sel = OPB_IMM;
                id_ex_o.imm     = {instr[31:12], 12'b0};
                writes_rd       = 1'b1;
            end
            `OPC_JAL: begin
                id_ex_o.valid     = 1'b1;
                id_ex_o.is_jal    = 1'b1;
                id_ex_o.opa_is_pc = 1'b1;
                id_ex_o.opb_sel   = OPB_PC4;
                id_ex_o.imm       = {{12{instr[31]}}, instr[19:12], instr[20],
                                     instr[30:21], 1'b0};
                writes_rd         = 1'b1;
            end
            `OPC_BRANCH: begin
                // beq, bne, blt, bge only
                id_ex_o.valid     = funct3 inside {3'b000, 3'b001, 3'b100, 3'b101};
                id_ex_o.is_branch = id_ex_o.valid;
                id_ex_o.imm       = {{20{instr[31]}}, instr[7], instr[30:25],
                                     instr[11:8], 1'b0};
            end
            default: ;
        endcase

        id_ex_o.pc              = if_id_i.pc;
        id_ex_o.rs1             = rs1;
        id_ex_o.rs2             = rs2;
        id_ex_o.rs1_data        = read_port(rs1);
        id_ex_o.rs2_data        = read_port(rs2);
        id_ex_o.rd              = rd;
        id_ex_o.rd_wren         = id_ex_o.valid && writes_rd && rd != '0;
        id_ex_o.funct3          = funct3;
        id_ex_o.predicted_taken = if_id_i.btb_hit && if_id_i.predicted_taken;
    end

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module execute_stage import rv_core_pkg::*; (
    input  id_ex_t                 id_ex_i,
    input  logic                   fwd_valid_i,
    input  logic [`REG_ADDR_W-1:0] fwd_rd_i,
    input  logic [`XLEN-1:0]       fwd_data_i,
    output ex_rt_t                 ex_rt_o
);

    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] opa;
    logic [`XLEN-1:0] opb;
    logic [`XLEN-1:0] alu_res;
    logic             fwd_ok;
    logic             br_cond;

    // Forward from the instruction now retiring
    assign fwd_ok  = fwd_valid_i && (fwd_rd_i != '0);
    assign rs1_val = (fwd_ok && fwd_rd_i == id_ex_i.rs1) ? fwd_data_i : id_ex_i.rs1_data;
    assign rs2_val = (fwd_ok && fwd_rd_i == id_ex_i.rs2) ? fwd_data_i : id_ex_i.rs2_data;

    assign opa = id_ex_i.opa_is_pc ? id_ex_i.pc : rs1_val;

    always_comb begin
        case (id_ex_i.opb_sel)
            OPB_IMM: opb = id_ex_i.imm;
            OPB_PC4: opb = `XLEN'd4;
            default: opb = rs2_val;
        endcase
    end

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_SUB:    alu_res = opa - opb;
            ALU_AND:    alu_res = opa & opb;
            ALU_OR:     alu_res = opa | opb;
            ALU_XOR:    alu_res = opa ^ opb;
            ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
            ALU_SLL:    alu_res = opa << opb[4:0];
            ALU_SRL:    alu_res = opa >> opb[4:0];
            ALU_PASS_B: alu_res = opb;
            default:    alu_res = opa + opb;
        endcase
    end

    // Compare the register values, not the ALU operands
    always_comb begin
        case (id_ex_i.funct3)
            3'b000:  br_cond = (rs1_val == rs2_val);
            3'b001:  br_cond = (rs1_val != rs2_val);
            3'b100:  br_cond = ($signed(rs1_val) < $signed(rs2_val));
            3'b101:  br_cond = ($signed(rs1_val) >= $signed(rs2_val));
            default: br_cond = 1'b0;
        endcase
    end

    always_comb begin
        ex_rt_o.valid           = id_ex_i.valid;
        ex_rt_o.pc              = id_ex_i.pc;
        ex_rt_o.rd              = id_ex_i.rd;
        ex_rt_o.rd_wren         = id_ex_i.rd_wren;
        ex_rt_o.result          = alu_res;
        ex_rt_o.is_ctrl         = id_ex_i.is_branch || id_ex_i.is_jal;
        ex_rt_o.taken           = id_ex_i.is_jal || (id_ex_i.is_branch && br_cond);
        // Both JAL and branches are pc-relative
        ex_rt_o.target          = id_ex_i.pc + id_ex_i.imm;
        ex_rt_o.predicted_taken = id_ex_i.predicted_taken;
    end

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module fetch_stage import rv_core_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     imem_we_i,
    input  logic [`IMEM_DEPTH_W-1:0] imem_addr_i,
    input  logic [`XLEN-1:0]         imem_data_i,
    input  logic                     flush_i,
    input  logic [`XLEN-1:0]         redirect_pc_i,
    input  logic                     pred_taken_i,
    input  logic [`XLEN-1:0]         pred_target_i,
    input  logic                     btb_hit_i,
    output logic [`XLEN-1:0]         fetch_pc_o,
    output if_id_t                   if_id_o
);

    logic [`XLEN-1:0]         imem [1 << `IMEM_DEPTH_W];
    logic [`XLEN-1:0]         pc_q;
    logic [`XLEN-1:0]         pc_next;
    logic [`IMEM_DEPTH_W-1:0] imem_idx;

    // Program load, only while the core is held in reset
    always_ff @(posedge clk_i) begin
        if (imem_we_i && !rst_ni) begin
            imem[imem_addr_i] <= imem_data_i;
        end
    end

    // Redirect from retire beats the prediction
    always_comb begin
        if (flush_i) begin
            pc_next = redirect_pc_i;
        end else if (pred_taken_i) begin
            pc_next = pred_target_i;
        end else begin
            pc_next = pc_q + `XLEN'd4;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign imem_idx   = pc_q[`IMEM_DEPTH_W+1:2];
    assign fetch_pc_o = pc_q;

    always_comb begin
        if_id_o.pc              = pc_q;
        if_id_o.instr           = imem[imem_idx];
        if_id_o.predicted_taken = pred_taken_i;
        if_id_o.btb_hit         = btb_hit_i;
    end

endmodule

/* design/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     clear_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // All-zero payload is a bubble, its valid field is low
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            q_o <= '0;
        end else if (clear_i) begin
            q_o <= '0;
        end else begin
            q_o <= d_i;
        end
    end

endmodule

/* design/rv_core_defs.svh */
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Data and address width
`define XLEN         32

// Register file address width
`define REG_ADDR_W   5

// BTB and PHT index width
`define BP_INDEX_W   6

// Instruction memory word address width
`define IMEM_DEPTH_W 8

// Major opcodes of the supported instructions
`define OPC_OP       7'b0110011
`define OPC_OP_IMM   7'b0010011
`define OPC_LUI      7'b0110111
`define OPC_JAL      7'b1101111
`define OPC_BRANCH   7'b1100011

`endif

/* design/rv_core_pkg.sv */
`include "rv_core_defs.svh"

package rv_core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_PASS_B = 4'd8
    } alu_op_e;

    // OPB_PC4 supplies the constant 4, so pc+4 comes out with opa_is_pc
    typedef enum logic [1:0] {
        OPB_REG = 2'd0,
        OPB_IMM = 2'd1,
        OPB_PC4 = 2'd2
    } opb_sel_e;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] instr;
        logic             predicted_taken;
        logic             btb_hit;
    } if_id_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       imm;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   rd_wren;
        alu_op_e                alu_op;
        logic                   opa_is_pc;
        opb_sel_e               opb_sel;
        logic                   is_branch;
        logic                   is_jal;
        logic [2:0]             funct3;
        logic                   predicted_taken;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   rd_wren;
        logic [`XLEN-1:0]       result;
        logic                   is_ctrl;
        logic                   taken;
        logic [`XLEN-1:0]       target;
        logic                   predicted_taken;
    } ex_rt_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   rd_wren;
        logic [`XLEN-1:0]       data;
    } retire_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic             taken;
        logic [`XLEN-1:0] target;
    } bp_update_t;

endpackage

/* design/rv_core_top.sv */
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_core_top import rv_core_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     imem_we_i,
    input  logic [`IMEM_DEPTH_W-1:0] imem_addr_i,
    input  logic [`XLEN-1:0]         imem_data_i,
    output retire_t                  retire_o
);

    if_id_t           if_id_d;
    if_id_t           if_id_q;
    id_ex_t           id_ex_d;
    id_ex_t           id_ex_q;
    ex_rt_t           ex_rt_d;
    ex_rt_t           ex_rt_q;
    bp_update_t       bp_update;
    logic [`XLEN-1:0] fetch_pc;
    logic [`XLEN-1:0] pred_target;
    logic [`XLEN-1:0] redirect_pc;
    logic             pred_taken;
    logic             btb_hit;
    logic             flush;
    logic             rt_wren;

    fetch_stage u_fetch (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .imem_we_i     (imem_we_i),
        .imem_addr_i   (imem_addr_i),
        .imem_data_i   (imem_data_i),
        .flush_i       (flush),
        .redirect_pc_i (redirect_pc),
        .pred_taken_i  (pred_taken),
        .pred_target_i (pred_target),
        .btb_hit_i     (btb_hit),
        .fetch_pc_o    (fetch_pc),
        .if_id_o       (if_id_d)
    );

    branch_predictor u_bp (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .rd_pc_i  (fetch_pc),
        .update_i (bp_update),
        .taken_o  (pred_taken),
        .target_o (pred_target),
        .hit_o    (btb_hit)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (flush),
        .d_i     (if_id_d),
        .q_o     (if_id_q)
    );

    decode_stage u_decode (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .if_id_i   (if_id_q),
        .wb_wren_i (rt_wren),
        .wb_addr_i (ex_rt_q.rd),
        .wb_data_i (ex_rt_q.result),
        .id_ex_o   (id_ex_d)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (flush),
        .d_i     (id_ex_d),
        .q_o     (id_ex_q)
    );

    execute_stage u_execute (
        .id_ex_i     (id_ex_q),
        .fwd_valid_i (rt_wren),
        .fwd_rd_i    (ex_rt_q.rd),
        .fwd_data_i  (ex_rt_q.result),
        .ex_rt_o     (ex_rt_d)
    );

    // The instruction in execute also follows the branch, so it is dropped too
    pipe_reg #(.payload_t(ex_rt_t)) u_ex_rt (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (flush),
        .d_i     (ex_rt_d),
        .q_o     (ex_rt_q)
    );

    // Non-control instructions resolve not-taken, so a stray prediction is caught
    assign flush       = ex_rt_q.valid && (ex_rt_q.taken != ex_rt_q.predicted_taken);
    assign redirect_pc = ex_rt_q.taken ? ex_rt_q.target : ex_rt_q.pc + `XLEN'd4;
    assign rt_wren     = ex_rt_q.valid && ex_rt_q.rd_wren;

    always_comb begin
        bp_update.valid  = ex_rt_q.valid && ex_rt_q.is_ctrl;
        bp_update.pc     = ex_rt_q.pc;
        bp_update.taken  = ex_rt_q.taken;
        bp_update.target = ex_rt_q.target;
    end

    always_comb begin
        retire_o.valid   = ex_rt_q.valid;
        retire_o.pc      = ex_rt_q.pc;
        retire_o.rd      = ex_rt_q.rd;
        retire_o.rd_wren = rt_wren;
        retire_o.data    = ex_rt_q.result;
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the simulation output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rv_core_tb \
    -f verilog.f -o rv_core_sim \
    && sim_out="$(./obj_dir/rv_core_sim)" \
    ; echo "${sim_out}" \
    && echo "${sim_out}" | grep -qx "TESTS PASSED" \
    && echo "run.sh: simulation ok" \
    || { echo "run.sh: simulation did not pass"; exit 1; }

/* verif/rv_core_properties.sv */
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_core_properties import rv_core_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  retire_t          retire_i,
    input  logic             ctrl_taken_i,
    input  logic [`XLEN-1:0] target_i
);

    logic             pending_q;
    logic [`XLEN-1:0] pending_target_q;
    logic [1:0]       fill_q;

    // Target of the last retired taken branch or jump
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q        <= 1'b0;
            pending_target_q <= '0;
        end else if (retire_i.valid) begin
            pending_q        <= ctrl_taken_i;
            pending_target_q <= target_i;
        end
    end

    // Edges since reset release, saturating once the pipeline is full
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            fill_q <= '0;
        end else if (fill_q != 2'd3) begin
            fill_q <= fill_q + 2'd1;
        end
    end

    valid_after_reset_a: assert property (@(posedge clk_i)
        (rst_ni && fill_q != 2'd3) |-> !retire_i.valid)
    else $error("retire valid is high before the pipeline has filled after reset");

    x0_write_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (retire_i.valid && retire_i.rd == '0) |-> !retire_i.rd_wren)
    else $error("a write to x0 retired with its write enable set");

    // Bubbles may sit between the control instruction and its target
    taken_target_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (retire_i.valid && pending_q) |-> retire_i.pc == pending_target_q)
    else $error("retired pc after a taken control instruction is not its target");

endmodule

/* verif/rv_core_tb.sv */
`timescale 1ns/1ps
`include "rv_core_defs.svh"

module rv_core_tb import rv_core_pkg::*; ();

    localparam int PROG_WORDS     = 32;
    localparam int MAX_RETIRES    = 64;
    localparam int NUM_TESTS      = 6;
    localparam int RESET_CYCLES   = 5;
    localparam int TIMEOUT_CYCLES = 200;

    logic                     clk;
    logic                     rst_n;
    logic                     imem_we;
    logic [`IMEM_DEPTH_W-1:0] imem_addr;
    logic [`XLEN-1:0]         imem_data;
    retire_t                  retire;

    logic [`XLEN-1:0]       prog [PROG_WORDS];
    int                     prog_len;
    logic [`XLEN-1:0]       exp_pc   [MAX_RETIRES];
    logic [`REG_ADDR_W-1:0] exp_rd   [MAX_RETIRES];
    logic                   exp_wren [MAX_RETIRES];
    logic [`XLEN-1:0]       exp_data [MAX_RETIRES];
    int                     exp_test [MAX_RETIRES];
    int                     exp_len;
    string                  test_name   [NUM_TESTS+1];
    int                     test_errors [NUM_TESTS+1];
    int                     errors;
    int                     checks;
    bit                     timed_out;

    rv_core_top i_dut (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .imem_we_i   (imem_we),
        .imem_addr_i (imem_addr),
        .imem_data_i (imem_data),
        .retire_o    (retire)
    );

    bind rv_core_top rv_core_properties u_props (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .retire_i     (retire_o),
        .ctrl_taken_i (ex_rt_q.valid && ex_rt_q.is_ctrl && ex_rt_q.taken),
        .target_i     (ex_rt_q.target)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Instruction encoders, arguments in assembler field order
    function automatic logic [31:0] op_word(input int f7, input int rs2, input int rs1,
                                            input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `OPC_OP};
    endfunction

    function automatic logic [31:0] imm_word(input int imm, input int rs1, input int f3,
                                             input int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], `OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] lui_word(input int upper, input int rd);
        return {upper[19:0], rd[4:0], `OPC_LUI};
    endfunction

    function automatic logic [31:0] branch_word(input int ofs, input int rs2, input int rs1,
                                                input int f3);
        return {ofs[12], ofs[10:5], rs2[4:0], rs1[4:0], f3[2:0], ofs[4:1], ofs[11],
                `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(input int ofs, input int rd);
        return {ofs[20], ofs[10:1], ofs[11], ofs[19:12], rd[4:0], `OPC_JAL};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic expect_rt(input int test, input logic [31:0] pc, input int rd,
                             input bit wren, input logic [31:0] data);
        exp_test[exp_len] = test;
        exp_pc[exp_len]   = pc;
        exp_rd[exp_len]   = rd[4:0];
        exp_wren[exp_len] = wren;
        exp_data[exp_len] = data;
        exp_len++;
    endtask

    task automatic build_tables();
        prog_len = 0;
        exp_len  = 0;
        for (int t = 0; t <= NUM_TESTS; t++) begin
            test_errors[t] = 0;
        end
        test_name[1] = "reset";
        test_name[2] = "alu chain";
        test_name[3] = "x0 writes";
        test_name[4] = "branch loop";
        test_name[5] = "jal";
        test_name[6] = "signed branches";

        emit(lui_word('h12345, 1));          // 0   lui  x1, 0x12345
        emit(imm_word('h678, 1, 0, 2));      // 4   addi x2, x1, 0x678
        emit(op_word(0, 2, 1, 0, 3));        // 8   add  x3, x2, x1
        emit(op_word('h20, 2, 3, 0, 4));     // 12  sub  x4, x3, x2
        emit(imm_word(-1, 4, 4, 5));         // 16  xori x5, x4, -1
        emit(op_word(0, 3, 5, 7, 6));        // 20  and  x6, x5, x3
        emit(op_word(0, 4, 6, 6, 7));        // 24  or   x7, x6, x4
        emit(imm_word(3, 0, 6, 8));          // 28  ori  x8, x0, 3
        emit(op_word(0, 8, 7, 1, 9));        // 32  sll  x9, x7, x8
        emit(op_word(0, 8, 9, 5, 10));       // 36  srl  x10, x9, x8
        emit(op_word(0, 4, 5, 2, 11));       // 40  slt  x11, x5, x4
        emit(imm_word('hF0, 7, 7, 12));      // 44  andi x12, x7, 0xf0
        emit(imm_word(5, 0, 0, 0));          // 48  addi x0, x0, 5
        emit(op_word(0, 0, 0, 0, 13));       // 52  add  x13, x0, x0
        emit(imm_word(0, 0, 0, 14));         // 56  addi x14, x0, 0
        emit(imm_word(8, 0, 0, 15));         // 60  addi x15, x0, 8
        emit(imm_word(1, 14, 0, 14));        // 64  addi x14, x14, 1
        emit(branch_word(-4, 15, 14, 1));    // 68  bne  x14, x15, -4
        emit(branch_word(8, 15, 14, 0));     // 72  beq  x14, x15, +8
        emit(imm_word(99, 0, 0, 16));        // 76  skipped
        emit(jal_word(8, 17));               // 80  jal  x17, +8
        emit(imm_word(1, 0, 0, 18));         // 84  skipped
        emit(imm_word(4, 17, 0, 18));        // 88  addi x18, x17, 4
        emit(imm_word(-5, 0, 0, 19));        // 92  addi x19, x0, -5
        emit(imm_word(3, 0, 0, 20));         // 96  addi x20, x0, 3
        emit(branch_word(8, 20, 19, 4));     // 100 blt  x19, x20, +8
        emit(imm_word(1, 0, 0, 21));         // 104 skipped
        emit(branch_word(8, 20, 19, 5));     // 108 bge  x19, x20, +8
        emit(branch_word(8, 19, 20, 5));     // 112 bge  x20, x19, +8
        emit(imm_word(2, 0, 0, 21));         // 116 skipped
        emit(imm_word(0, 19, 2, 21));        // 120 slti x21, x19, 0
        emit(jal_word(0, 0));                // 124 jal  x0, 0

        // Architectural retire order, rd and data matter only with wren set
        expect_rt(1, 0, 1, 1, 'h12345000);
        expect_rt(2, 4, 2, 1, 'h12345678);
        expect_rt(2, 8, 3, 1, 'h2468A678);
        expect_rt(2, 12, 4, 1, 'h12345000);
        expect_rt(2, 16, 5, 1, 'hEDCBAFFF);
        expect_rt(2, 20, 6, 1, 'h2448A678);
        expect_rt(2, 24, 7, 1, 'h367CF678);
        expect_rt(2, 28, 8, 1, 3);
        expect_rt(2, 32, 9, 1, 'hB3E7B3C0);
        expect_rt(2, 36, 10, 1, 'h167CF678);
        expect_rt(2, 40, 11, 1, 1);
        expect_rt(2, 44, 12, 1, 'h70);
        expect_rt(3, 48, 0, 0, 0);
        expect_rt(3, 52, 13, 1, 0);
        expect_rt(4, 56, 14, 1, 0);
        expect_rt(4, 60, 15, 1, 8);
        for (int i = 1; i <= 8; i++) begin
            expect_rt(4, 64, 14, 1, i);
            expect_rt(4, 68, 0, 0, 0);
        end
        expect_rt(4, 72, 0, 0, 0);
        expect_rt(5, 80, 17, 1, 84);
        expect_rt(5, 88, 18, 1, 88);
        expect_rt(6, 92, 19, 1, 'hFFFFFFFB);
        expect_rt(6, 96, 20, 1, 3);
        expect_rt(6, 100, 0, 0, 0);
        expect_rt(6, 108, 0, 0, 0);
        expect_rt(6, 112, 0, 0, 0);
        expect_rt(6, 120, 21, 1, 1);
        expect_rt(6, 124, 0, 0, 0);
    endtask

    // Whole memory written, unused words are nops carrying their own address
    task automatic load_program();
        for (int a = 0; a < (1 << `IMEM_DEPTH_W); a++) begin
            @(posedge clk);
            #1;
            imem_we   = 1'b1;
            imem_addr = a[`IMEM_DEPTH_W-1:0];
            imem_data = (a < prog_len) ? prog[a] : imm_word(a, 0, 0, 0);
        end
        @(posedge clk);
        #1;
        imem_we = 1'b0;
    endtask

    task automatic wait_retire(output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            if (retire.valid) begin
                ok = 1'b1;
            end
            cycles++;
        end
    endtask

    task automatic check_entry(input int n);
        int t;
        t = exp_test[n];
        checks++;
        if (retire.pc !== exp_pc[n]) begin
            $display("MISMATCH at %0t: entry %0d pc %h, expected %h",
                     $time, n, retire.pc, exp_pc[n]);
            errors++;
            test_errors[t]++;
        end
        if (retire.rd_wren !== exp_wren[n]) begin
            $display("MISMATCH at %0t: entry %0d rd_wren %b, expected %b",
                     $time, n, retire.rd_wren, exp_wren[n]);
            errors++;
            test_errors[t]++;
        end
        if (exp_wren[n] && retire.rd !== exp_rd[n]) begin
            $display("MISMATCH at %0t: entry %0d rd x%0d, expected x%0d",
                     $time, n, retire.rd, exp_rd[n]);
            errors++;
            test_errors[t]++;
        end
        if (exp_wren[n] && retire.data !== exp_data[n]) begin
            $display("MISMATCH at %0t: entry %0d data %h, expected %h",
                     $time, n, retire.data, exp_data[n]);
            errors++;
            test_errors[t]++;
        end
    endtask

    task automatic report_test(input int t);
        if (test_errors[t] == 0) begin
            $display("test %0d %s: ok", t, test_name[t]);
        end else begin
            $display("test %0d %s: %0d errors", t, test_name[t], test_errors[t]);
        end
    endtask

    initial begin
        bit got;
        rst_n     = 1'b0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;

        build_tables();
        load_program();

        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            #1;
            checks++;
            if (retire.valid) begin
                $display("MISMATCH at %0t: retire valid high during reset", $time);
                errors++;
                test_errors[1]++;
            end
        end
        rst_n = 1'b1;

        for (int n = 0; n < exp_len && !timed_out; n++) begin
            wait_retire(got);
            if (!got) begin
                $display("timeout: entry %0d (pc %0d) did not retire within %0d cycles",
                         n, exp_pc[n], TIMEOUT_CYCLES);
                timed_out = 1'b1;
                errors++;
            end else begin
                check_entry(n);
                if (n == exp_len - 1 || exp_test[n+1] != exp_test[n]) begin
                    report_test(exp_test[n]);
                end
            end
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+design
design/rv_core_pkg.sv
design/pipe_reg.sv
design/branch_predictor.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/rv_core_top.sv
verif/rv_core_properties.sv
verif/rv_core_tb.sv
